//--- hw/mem_pkg.sv
package mem_pkg;

    // --------------------------------------------------
    // geometry
    localparam int addr_width        = 32;  // byte address
    localparam int data_width        = 32;
    localparam int mem_depth         = 256; // words
    localparam int word_index_width  = $clog2(mem_depth);
    localparam int byte_offset_width = 2;   // bytes within a word

    // --------------------------------------------------
    // timing
    localparam int mem_delay         = 4;   // accept to ack, at least 1
    localparam int delay_cnt_width   = $clog2(mem_delay + 1);

    // counter start value, reaches zero in the cycle before ack
    localparam logic [delay_cnt_width-1:0] delay_load =
        delay_cnt_width'(mem_delay - 1);

endpackage

//--- hw/arb_pkg.sv
package arb_pkg;

    // --------------------------------------------------
    // requesters
    localparam int num_requesters = 2;
    localparam int port_width     = $clog2(num_requesters);

    // port index, lower index wins
    localparam logic [port_width-1:0] port_data  = port_width'(0);
    localparam logic [port_width-1:0] port_fetch = port_width'(1);

endpackage

//--- hw/mem_delayed.sv
`timescale 1ns/1ns

module mem_delayed (
    input  logic                               clk,
    input  logic                               rst,

    input  logic                               rd_req,
    input  logic                               wr_req,

    input  logic [mem_pkg::addr_width-1:0]     addr,
    output logic [mem_pkg::data_width-1:0]     rd_data,
    input  logic [mem_pkg::data_width-1:0]     wr_data,

    output logic                               busy,
    output logic                               ack,

    input  logic                               oob_wen,
    input  logic [mem_pkg::word_index_width-1:0] oob_wr_addr,
    input  logic [mem_pkg::data_width-1:0]     oob_wr_data
);
    import mem_pkg::*;

    logic [data_width-1:0]       mem [mem_depth];

    logic [word_index_width-1:0] req_index; // folded word index
    logic [data_width-1:0]       req_data;
    logic                        req_write;
    logic [delay_cnt_width-1:0]  cnt;

    logic                        accept;
    logic                        finish;

    assign accept = !busy && (rd_req || wr_req);
    assign finish = busy && (cnt == '0);

    // --------------------------------------------------
    // request tracking
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            ack       <= 1'b0;
            cnt       <= '0;
            req_write <= 1'b0;
        end else begin
            ack <= finish;
            if (accept) begin
                busy      <= 1'b1;
                cnt       <= delay_load;
                req_write <= wr_req; // write wins
            end else if (finish) begin
                busy <= 1'b0;
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_index <= addr[word_index_width+byte_offset_width-1:byte_offset_width];
            req_data  <= wr_data;
        end
    end

    // --------------------------------------------------
    // storage
    always_ff @(posedge clk) begin
        if (oob_wen) begin
            mem[oob_wr_addr] <= oob_wr_data; // preload path
        end
        if (finish && req_write) begin
            mem[req_index] <= req_data;
        end
    end

    // read data only in the ack cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_data <= '0;
        end else if (finish && !req_write) begin
            rd_data <= mem[req_index];
        end else begin
            rd_data <= '0;
        end
    end

    // --------------------------------------------------
    // checks
    ack_one_cycle: assert property (
        @(posedge clk) disable iff (rst) ack |=> !ack
    );

    // arbiter must present a single kind of access
    req_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(rd_req && wr_req)
    );

endmodule

//--- hw/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
    input  logic                           clk,
    input  logic                           rst,

    // fetch side
    input  logic                           fetch_req,
    input  logic [mem_pkg::addr_width-1:0] fetch_addr,
    output logic [mem_pkg::data_width-1:0] fetch_rdata,
    output logic                           fetch_ack,

    // data side
    input  logic                           data_req,
    input  logic                           data_we,
    input  logic [mem_pkg::addr_width-1:0] data_addr,
    input  logic [mem_pkg::data_width-1:0] data_wdata,
    output logic [mem_pkg::data_width-1:0] data_rdata,
    output logic                           data_ack,

    // memory side
    output logic                           mem_rd_req,
    output logic                           mem_wr_req,
    output logic [mem_pkg::addr_width-1:0] mem_addr,
    output logic [mem_pkg::data_width-1:0] mem_wr_data,
    input  logic [mem_pkg::data_width-1:0] mem_rd_data,
    input  logic                           mem_busy,
    input  logic                           mem_ack
);
    import mem_pkg::*;
    import arb_pkg::*;

    logic                  locked;
    logic [port_width-1:0] owner;

    logic [port_width-1:0] sel_port;
    logic                  sel_req;
    logic                  sel_we;
    logic [addr_width-1:0] sel_addr;
    logic                  grant;
    logic                  present;

    // --------------------------------------------------
    // selection
    always_comb begin
        if (locked) begin
            sel_port = owner; // hold until ack
        end else if (data_req) begin
            sel_port = port_data;
        end else begin
            sel_port = port_fetch;
        end
    end

    assign sel_req  = (sel_port == port_data) ? data_req : fetch_req;
    assign sel_we   = (sel_port == port_data) && data_we;
    assign sel_addr = (sel_port == port_data) ? data_addr : fetch_addr;

    assign grant    = !locked && !mem_busy && sel_req;
    assign present  = (locked || grant) && sel_req && !mem_ack; // no re-accept on ack

    assign mem_rd_req  = present && !sel_we;
    assign mem_wr_req  = present && sel_we;
    assign mem_addr    = sel_addr;
    assign mem_wr_data = data_wdata; // only data port writes

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            locked <= 1'b0;
            owner  <= port_data;
        end else if (mem_ack) begin
            locked <= 1'b0;
        end else if (grant) begin
            locked <= 1'b1;
            owner  <= sel_port;
        end
    end

    // --------------------------------------------------
    // response steering
    assign data_ack    = mem_ack && (owner == port_data);
    assign fetch_ack   = mem_ack && (owner == port_fetch);
    assign data_rdata  = data_ack ? mem_rd_data : '0;
    assign fetch_rdata = fetch_ack ? mem_rd_data : '0;

    ack_while_locked: assert property (
        @(posedge clk) disable iff (rst) mem_ack |-> locked
    );

endmodule

//--- hw/mem_subsys.sv
`timescale 1ns/1ns

module mem_subsys (
    input  logic                                 clk,
    input  logic                                 rst,

    input  logic                                 fetch_req,
    input  logic [mem_pkg::addr_width-1:0]       fetch_addr,
    output logic [mem_pkg::data_width-1:0]       fetch_rdata,
    output logic                                 fetch_ack,

    input  logic                                 data_req,
    input  logic                                 data_we,
    input  logic [mem_pkg::addr_width-1:0]       data_addr,
    input  logic [mem_pkg::data_width-1:0]       data_wdata,
    output logic [mem_pkg::data_width-1:0]       data_rdata,
    output logic                                 data_ack,

    input  logic                                 oob_wen,
    input  logic [mem_pkg::word_index_width-1:0] oob_wr_addr,
    input  logic [mem_pkg::data_width-1:0]       oob_wr_data
);
    import mem_pkg::*;

    // --------------------------------------------------
    // arbiter to memory
    logic                  mem_rd_req;
    logic                  mem_wr_req;
    logic [addr_width-1:0] mem_addr;
    logic [data_width-1:0] mem_wr_data;
    logic [data_width-1:0] mem_rd_data;
    logic                  mem_busy;
    logic                  mem_ack;

    mem_arbiter u_arb (
        .clk         (clk),
        .rst         (rst),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_rdata (fetch_rdata),
        .fetch_ack   (fetch_ack),
        .data_req    (data_req),
        .data_we     (data_we),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_rdata  (data_rdata),
        .data_ack    (data_ack),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_data (mem_rd_data),
        .mem_busy    (mem_busy),
        .mem_ack     (mem_ack)
    );

    mem_delayed u_mem (
        .clk         (clk),
        .rst         (rst),
        .rd_req      (mem_rd_req),
        .wr_req      (mem_wr_req),
        .addr        (mem_addr),
        .rd_data     (mem_rd_data),
        .wr_data     (mem_wr_data),
        .busy        (mem_busy),
        .ack         (mem_ack),
        .oob_wen     (oob_wen),
        .oob_wr_addr (oob_wr_addr),
        .oob_wr_data (oob_wr_data)
    );

endmodule

//--- tests/mem_model.svh
`ifndef MEM_MODEL_SVH
`define MEM_MODEL_SVH

// expected word contents, indexed like the memory array
logic [mem_pkg::data_width-1:0] model_mem [mem_pkg::mem_depth];

// byte address to word index, wrapping at the array size
function automatic int fold_index(input logic [mem_pkg::addr_width-1:0] addr);
    return int'((addr >> 2) % mem_pkg::mem_depth);
endfunction

task automatic model_preload(input int index, input logic [mem_pkg::data_width-1:0] data);
    model_mem[index % mem_pkg::mem_depth] = data;
endtask

task automatic model_write(input logic [mem_pkg::addr_width-1:0] addr,
                           input logic [mem_pkg::data_width-1:0] data);
    model_mem[fold_index(addr)] = data;
endtask

task automatic model_read(input  logic [mem_pkg::addr_width-1:0] addr,
                          output logic [mem_pkg::data_width-1:0] data);
    data = model_mem[fold_index(addr)];
endtask

`endif

//--- tests/mem_subsys_tb.sv
`timescale 1ns/1ns

module mem_subsys_tb;
    import mem_pkg::*;

    localparam int ack_timeout = 50; // cycles per wait

    logic                        clk;
    logic                        rst;
    logic                        fetch_req;
    logic [addr_width-1:0]       fetch_addr;
    logic [data_width-1:0]       fetch_rdata;
    logic                        fetch_ack;
    logic                        data_req;
    logic                        data_we;
    logic [addr_width-1:0]       data_addr;
    logic [data_width-1:0]       data_wdata;
    logic [data_width-1:0]       data_rdata;
    logic                        data_ack;
    logic                        oob_wen;
    logic [word_index_width-1:0] oob_wr_addr;
    logic [data_width-1:0]       oob_wr_data;

    int error_count;
    int seed_value;

    `include "mem_model.svh"

    mem_subsys u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    // --------------------------------------------------
    // helpers
    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {idx, ~idx, idx ^ 8'h5a, 8'hc3};
    endfunction

    task automatic report_mismatch(input string test_name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        error_count++;
        $display("FAILED %s: expected %h, actual %h", test_name, expected, actual);
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR %s", msg);
    endtask

    // one request on one port, returns read data and edges from sampling to ack
    task automatic run_access(input string test_name, input bit use_data, input logic we,
                              input logic [addr_width-1:0] addr,
                              input logic [data_width-1:0] wdata,
                              output logic [data_width-1:0] rdata, output int cycles);
        logic                  ack_seen;
        logic                  my_ack;
        logic                  other_ack;
        logic [data_width-1:0] my_rdata;
        int                    waited;
        @(negedge clk);
        if (use_data) begin
            data_req   = 1'b1;
            data_we    = we;
            data_addr  = addr;
            data_wdata = wdata;
        end else begin
            fetch_req  = 1'b1;
            fetch_addr = addr;
        end
        ack_seen = 1'b0;
        waited   = 0;
        rdata    = '0;
        while (!ack_seen && waited < ack_timeout) begin
            @(negedge clk);
            waited++;
            my_ack    = use_data ? data_ack : fetch_ack;
            other_ack = use_data ? fetch_ack : data_ack;
            my_rdata  = use_data ? data_rdata : fetch_rdata;
            if (other_ack)
                report_error({test_name, ": ack reached the port that made no request"});
            if (my_ack) begin
                ack_seen = 1'b1;
                rdata    = my_rdata;
            end else if (my_rdata !== '0) begin
                report_mismatch({test_name, " rdata outside ack"}, '0, my_rdata);
            end
        end
        if (!ack_seen)
            report_error($sformatf("%s: no ack within %0d cycles", test_name, ack_timeout));
        cycles    = waited - 1; // first edge samples req
        data_req  = 1'b0; // drop in the ack cycle
        data_we   = 1'b0;
        fetch_req = 1'b0;
    endtask

    task automatic read_check(input string test_name, input bit use_data,
                              input logic [addr_width-1:0] addr);
        logic [data_width-1:0] got;
        logic [data_width-1:0] expected;
        int                    cycles;
        run_access(test_name, use_data, 1'b0, addr, '0, got, cycles);
        model_read(addr, expected);
        if (got !== expected)
            report_mismatch(test_name, expected, got);
    endtask

    task automatic write_data(input string test_name, input logic [addr_width-1:0] addr,
                              input logic [data_width-1:0] wdata);
        logic [data_width-1:0] got;
        int                    cycles;
        run_access(test_name, 1'b1, 1'b1, addr, wdata, got, cycles);
        model_write(addr, wdata);
    endtask

    // --------------------------------------------------
    // tests
    task automatic test_preload_fetch();
        for (int i = 0; i < mem_depth; i++) begin
            @(negedge clk);
            oob_wen     = 1'b1;
            oob_wr_addr = word_index_width'(i);
            oob_wr_data = fill_word(8'(i));
            model_preload(i, fill_word(8'(i)));
        end
        @(negedge clk);
        oob_wen = 1'b0;
        read_check("preload_fetch", 1'b0, 32'h0000_0000);
        read_check("preload_fetch", 1'b0, 32'h0000_0004);
        read_check("preload_fetch", 1'b0, 32'h0000_0094);
        read_check("preload_fetch", 1'b0, 32'h0000_03fc); // last word
    endtask

    task automatic test_write_read();
        write_data("write_read", 32'h0000_0120, 32'hdead_beef);
        for (int b = 0; b < 4; b++)
            read_check("write_read", 1'b1, 32'h0000_0120 | b);
        read_check("write_read", 1'b0, 32'h0000_0123);
    endtask

    task automatic test_latency();
        logic [data_width-1:0] got;
        int                    cycles;
        run_access("latency", 1'b1, 1'b0, 32'h0000_0040, '0, got, cycles);
        if (cycles != mem_delay)
            report_mismatch("latency data read", mem_delay, cycles);
        run_access("latency", 1'b0, 1'b0, 32'h0000_0044, '0, got, cycles);
        if (cycles != mem_delay)
            report_mismatch("latency fetch read", mem_delay, cycles);
        run_access("latency", 1'b1, 1'b1, 32'h0000_0048, 32'h0bad_cafe, got, cycles);
        model_write(32'h0000_0048, 32'h0bad_cafe);
        if (cycles != mem_delay)
            report_mismatch("latency data write", mem_delay, cycles);
    endtask

    // both ports raise req together, data must finish first
    task automatic test_contention(input logic we, input logic [addr_width-1:0] d_addr,
                                   input logic [data_width-1:0] wdata,
                                   input logic [addr_width-1:0] f_addr);
        logic                  data_done;
        logic                  fetch_done;
        logic [data_width-1:0] expected;
        int                    cycles;
        @(negedge clk);
        data_req   = 1'b1;
        data_we    = we;
        data_addr  = d_addr;
        data_wdata = wdata;
        fetch_req  = 1'b1;
        fetch_addr = f_addr;
        data_done  = 1'b0;
        fetch_done = 1'b0;
        cycles     = 0;
        while (!(data_done && fetch_done) && cycles < ack_timeout) begin
            @(negedge clk);
            cycles++;
            if (data_ack && fetch_ack)
                report_error("contention: both ports acked in the same cycle");
            if (fetch_ack) begin
                if (!data_done)
                    report_error("contention: fetch port acked before the data port");
                fetch_done = 1'b1;
                fetch_req  = 1'b0;
                model_read(f_addr, expected);
                if (fetch_rdata !== expected)
                    report_mismatch("contention fetch", expected, fetch_rdata);
            end
            if (data_ack) begin
                data_done = 1'b1;
                data_req  = 1'b0;
                data_we   = 1'b0;
                if (we) begin
                    model_write(d_addr, wdata);
                end else begin
                    model_read(d_addr, expected);
                    if (data_rdata !== expected)
                        report_mismatch("contention data", expected, data_rdata);
                end
            end
        end
        if (!(data_done && fetch_done))
            report_error("contention: acks missing after the timeout");
        data_req  = 1'b0;
        fetch_req = 1'b0;
    endtask

    task automatic test_random();
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
        bit                    use_data;
        for (int k = 0; k < 40; k++) begin
            use_data = $urandom % 2;
            addr     = $urandom & 32'h0000_0fff; // spans four aliases of the array
            if (use_data && ($urandom % 2)) begin
                wdata = $urandom;
                write_data("random", addr, wdata);
            end else begin
                read_check("random", use_data, addr);
            end
        end
    endtask

    // --------------------------------------------------
    // main sequence
    initial begin
        seed_value  = 6;
        void'($urandom(seed_value));
        error_count = 0;
        rst         = 1'b1;
        fetch_req   = 1'b0;
        fetch_addr  = '0;
        data_req    = 1'b0;
        data_we     = 1'b0;
        data_addr   = '0;
        data_wdata  = '0;
        oob_wen     = 1'b0;
        oob_wr_addr = '0;
        oob_wr_data = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (u_dut.u_mem.busy !== 1'b0 || data_ack !== 1'b0 || fetch_ack !== 1'b0 ||
            data_rdata !== '0 || fetch_rdata !== '0)
            report_error("outputs not idle after reset");
        test_preload_fetch();
        test_write_read();
        test_latency();
        test_contention(1'b1, 32'h0000_0200, 32'h1234_5678, 32'h0000_0202);
        test_contention(1'b0, 32'h0000_0094, '0, 32'h0000_0120);
        test_random();
        $display("errors: %0d", error_count);
        if (error_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+tests
hw/mem_pkg.sv
hw/arb_pkg.sv
hw/mem_delayed.sv
hw/mem_arbiter.sv
hw/mem_subsys.sv
tests/mem_subsys_tb.sv
